// File: tb.f
+incdir+verilog
verilog/zx_pkg.sv
verilog/zx_cpu_bus_if.sv
verilog/zx_bus_decode.sv
verilog/zx_ula_port.sv
verilog/zx_paging.sv
verilog/zx_mem_access.sv
verilog/zx_bus_core.sv
sim/tb_clock.sv
sim/zx_bus_core_asserts.sv
sim/tb_zx_bus_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_zx_bus_core -f tb.f \
	-o tb_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation did not pass, see sim.log"; exit 1; }

// File: sim/tb_zx_bus_core.sv
// ====================
// Directed testbench for the bus core
// Memory model acks after 1 to 4 cycles and fills unwritten bytes from the address
// Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
// Stops at the first error
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

module tb_zx_bus_core
	import zx_pkg::*;
();

	// Four resets and about 30 bus cycles of at most 12 clocks fit well below this
	localparam int max_cycles = 3000;
	localparam logic [31:0] lcg_seed = 32'hac06_105f;

	logic        clk_sys;
	logic        reset;
	logic [15:0] bus_addr;
	logic [7:0]  bus_wdata, bus_rdata;
	logic        bus_mreq, bus_iorq, bus_rd, bus_wr, bus_m1;
	logic        cpu_wait, mem_req, mem_ack, mem_we;
	logic [19:0] mem_addr;
	logic [7:0]  mem_wdata, mem_rdata;
	logic [1:0]  model;
	logic [4:0]  key_data;
	logic        tape_in;
	logic [5:0]  joystick;
	logic [2:0]  border;
	logic        ear, mic, screen_page;

	logic [7:0]  mem_model [logic [19:0]];
	logic [19:0] last_addr;
	logic        last_we;
	logic [7:0]  last_wdata;
	logic [31:0] data_state = lcg_seed;
	int          req_count = 0;
	int          cycle_count = 0;

	tb_clock i_clock (.clk_sys);

	zx_bus_core i_dut (.*);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Unwritten memory reads back a pattern of the whole address
	function automatic logic [7:0] fill_byte(input logic [19:0] a);
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]} ^ 8'h5A;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	// ====================
	// Compare tasks
	// ====================
	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch %s expected %02h actual %02h",
				name, expected, actual));
		end
	endtask

	task automatic check_addr(input string name, input logic [19:0] expected,
		input logic [19:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch %s expected %05h actual %05h",
				name, expected, actual));
		end
	endtask

	task automatic check_ula(input string name, input zx_ula_wr_t expected,
		input zx_ula_wr_t actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch %s expected %02h actual %02h",
				name, expected, actual));
		end
	endtask

	// ====================
	// Memory responder
	// ====================
	initial begin : responder
		logic [31:0] delay_state;
		delay_state = lcg_seed;
		mem_ack = 1'b0;
		mem_rdata = 8'h00;
		forever begin
			@(negedge clk_sys);
			if (mem_req) begin
				req_count++;
				last_addr = mem_addr;
				last_we = mem_we;
				last_wdata = mem_wdata;
				delay_state = lcg_step(delay_state);
				repeat (int'(delay_state[1:0]) + 1) @(posedge clk_sys);
				#1;
				if (last_we) mem_model[last_addr] = last_wdata;
				mem_rdata = mem_model.exists(last_addr) ? mem_model[last_addr] :
					fill_byte(last_addr);
				mem_ack = 1'b1;
				while (mem_req) @(negedge clk_sys);
				@(posedge clk_sys);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_sys) begin
		cycle_count++;
		if (cycle_count > max_cycles) begin
			report_failure("Timeout: the tests did not finish in time");
		end else if (i_dut.i_mem.i_asserts.hold_fail || i_dut.i_mem.i_asserts.rise_fail ||
			i_dut.i_mem.i_asserts.wait_fail) begin
			report_failure("A memory handshake assertion failed");
		end
	end

	// ====================
	// Bus tasks
	// ====================
	task automatic drive_bus(input logic [15:0] a, input logic [7:0] d, input logic mreq,
		input logic iorq, input logic rd, input logic wr);
		@(posedge clk_sys);
		#1;
		bus_addr = a;
		bus_wdata = d;
		bus_mreq = mreq;
		bus_iorq = iorq;
		bus_rd = rd;
		bus_wr = wr;
	endtask

	task automatic apply_reset(input logic [1:0] m);
		@(posedge clk_sys);
		#1;
		model = m;
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		#1 reset = 1'b0;
	endtask

	// Write checks the request fields, read checks bus_rdata
	task automatic mem_access(input string name, input logic we, input logic [15:0] addr,
		input logic [5:0] page, input logic [7:0] data);
		int n;
		int reqs;
		n = 0;
		reqs = req_count;
		drive_bus(addr, data, 1'b1, 1'b0, !we, we);
		do begin
			@(negedge clk_sys);
			n++;
		end while (!cpu_wait && n < 4);
		if (!cpu_wait) report_failure({name, ": cpu_wait did not rise"});
		while (cpu_wait) @(negedge clk_sys);
		if (req_count == reqs) report_failure({name, ": no mem_req for the access"});
		check_addr(name, {page, addr[13:0]}, last_addr);
		check_byte({name, " mem_we"}, {7'd0, we}, {7'd0, last_we});
		check_byte(name, data, we ? last_wdata : bus_rdata);
		drive_bus(addr, data, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic map_read(input string name, input logic [15:0] addr, input logic [5:0] page);
		mem_access(name, 1'b0, addr, page, fill_byte({page, addr[13:0]}));
	endtask

	task automatic ram_check(input string name, input logic [15:0] addr, input logic [5:0] page);
		data_state = lcg_step(data_state);
		mem_access(name, 1'b1, addr, page, data_state[7:0]);
		mem_access(name, 1'b0, addr, page, data_state[7:0]);
	endtask

	task automatic rom_write(input string name, input logic [15:0] addr);
		drive_bus(addr, 8'hAA, 1'b1, 1'b0, 1'b0, 1'b1);
		repeat (4) begin
			@(negedge clk_sys);
			if (mem_req || cpu_wait) report_failure({name, ": ROM area write raised mem_req"});
		end
		drive_bus(addr, 8'hAA, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic io_write(input logic [15:0] addr, input zx_io_data_u d);
		drive_bus(addr, d, 1'b0, 1'b1, 1'b0, 1'b1);
		repeat (2) @(posedge clk_sys);
		drive_bus(addr, d, 1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge clk_sys);
	endtask

	task automatic io_read(input string name, input logic [15:0] addr,
		input logic [7:0] expected);
		drive_bus(addr, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
		@(negedge clk_sys);
		check_byte(name, expected, bus_rdata);
		drive_bus(addr, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic test_rom_read();
		apply_reset(`ZX_MODEL_128);
		map_read("rom_read", 16'h0123, 6'd32);
	endtask

	task automatic test_paging();
		zx_io_data_u d;
		d = '0;
		d.page.bank = 3'd3;
		d.page.rom = 1'b1;
		io_write(16'h7FFD, d);
		map_read("page_c000", 16'hC123, 6'd3);
		map_read("page_rom1", 16'h0010, 6'd33);
		map_read("page_4000", 16'h4000, 6'd5);
		map_read("page_8000", 16'h8000, 6'd2);
		ram_check("ram_c000", 16'hC200, 6'd3);
		ram_check("ram_8000", 16'h8345, 6'd2);
	endtask

	task automatic test_lock();
		zx_io_data_u d;
		d = '0;
		d.page.lock = 1'b1;
		d.page.bank = 3'd1;
		io_write(16'h7FFD, d);
		map_read("lock_set", 16'hC000, 6'd1);
		d.page.lock = 1'b0;
		d.page.bank = 3'd6;
		io_write(16'h7FFD, d);
		map_read("lock_held", 16'hC000, 6'd1);
		rom_write("rom_write", 16'h0100);
		apply_reset(`ZX_MODEL_128);
		io_write(16'h7FFD, d);
		map_read("lock_cleared", 16'hC000, 6'd6);
	endtask

	task automatic ula_case(input string name, input logic [2:0] b, input logic e,
		input logic m);
		zx_io_data_u d;
		zx_ula_wr_t  actual;
		d = '0;
		d.ula.border = b;
		d.ula.ear = e;
		d.ula.mic = m;
		io_write(16'h00FE, d);
		actual = '0;
		actual.border = border;
		actual.ear = ear;
		actual.mic = mic;
		check_ula(name, d.ula, actual);
	endtask

	task automatic test_ula();
		zx_io_data_u d;
		ula_case("ula_mic", 3'd5, 1'b0, 1'b1);
		ula_case("ula_ear", 3'd2, 1'b1, 1'b0);
		d = '0;
		d.page.scr = 1'b1;
		io_write(16'h7FFD, d);
		check_byte("screen_page", 8'd1, {7'd0, screen_page});
		d.page.scr = 1'b0;
		io_write(16'h7FFD, d);
		check_byte("screen_page_clear", 8'd0, {7'd0, screen_page});
	endtask

	task automatic test_ports();
		@(posedge clk_sys);
		#1;
		key_data = 5'h15;
		tape_in = 1'b1;
		joystick = 6'h2A;
		// Bit 6 carries the inverted tape input
		io_read("port_fe", 16'hFEFE, {1'b1, 1'b0, 1'b1, 5'h15});
		io_read("port_1f", 16'h001F, {2'b00, 6'h2A});
		io_read("port_idle", 16'h00FF, `ZX_IDLE_BYTE);
	endtask

	task automatic test_models();
		zx_io_data_u d;
		d = '0;
		d.page.ext = 2'b11;
		d.page.bank = 3'd4;
		io_write(16'h7FFD, d);
		// Extension bits are dropped outside the P512 model
		map_read("m128_ext", 16'hC040, 6'd4);
		apply_reset(`ZX_MODEL_P512);
		d = '0;
		d.page.ext = 2'b10;
		d.page.bank = 3'd5;
		io_write(16'h7FFD, d);
		map_read("p512_ext", 16'hC040, {1'b0, 2'b10, 3'd5});
		apply_reset(`ZX_MODEL_48);
		map_read("m48_rom", 16'h0040, 6'd33);
		d = '0;
		d.page.bank = 3'd7;
		io_write(16'h7FFD, d);
		map_read("m48_paging", 16'hC040, 6'd0);
	endtask

	initial begin
		reset = 1'b1;
		bus_addr = 16'h0000;
		bus_wdata = 8'h00;
		bus_mreq = 1'b0;
		bus_iorq = 1'b0;
		bus_rd = 1'b0;
		bus_wr = 1'b0;
		bus_m1 = 1'b0;
		model = `ZX_MODEL_128;
		key_data = 5'h1F;
		tape_in = 1'b0;
		joystick = 6'h00;
		test_rom_read();
		test_paging();
		test_lock();
		test_ula();
		test_ports();
		test_models();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: sim/zx_bus_core_asserts.sv
// ====================
// Memory handshake rules, bound into zx_mem_access
// Not checked while reset is high
// Each rule also raises its own flag for the testbench
// ====================
`timescale 1ns/1ps

module zx_bus_core_asserts (
	input logic clk_sys,
	input logic reset,
	input logic mem_req,
	input logic mem_ack,
	input logic cpu_wait
);

	logic hold_fail = 1'b0;
	logic rise_fail = 1'b0;
	logic wait_fail = 1'b0;

	// Request stays up until the memory answers
	req_hold_a: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req && !mem_ack |=> mem_req)
	else begin
		hold_fail = 1'b1;
		$error("mem_req fell before mem_ack");
	end

	// Four-phase rule, a new request waits for ack low
	req_rise_a: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_req) |-> !mem_ack)
	else begin
		rise_fail = 1'b1;
		$error("mem_req rose while mem_ack was high");
	end

	cpu_wait_a: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req || mem_ack) |-> cpu_wait)
	else begin
		wait_fail = 1'b1;
		$error("cpu_wait low during a memory handshake");
	end

endmodule

bind zx_mem_access zx_bus_core_asserts i_asserts (
	.clk_sys, .reset, .mem_req, .mem_ack, .cpu_wait
);

// File: sim/tb_clock.sv
// ====================
// Testbench clock, 20 ns period
// Starts low at time zero
// ====================
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys
);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

endmodule

// File: verilog/zx_bus_core.sv
// ====================
// ZX Spectrum bus core top level
// Z80-style bus in, active high strobes
// External memory on a four-phase req/ack port
// Unmapped port reads return FF
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

module zx_bus_core
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_AW-1:0]     bus_addr,
	input  logic [`ZX_DW-1:0]     bus_wdata,
	input  logic                  bus_mreq,
	input  logic                  bus_iorq,
	input  logic                  bus_rd,
	input  logic                  bus_wr,
	input  logic                  bus_m1,
	output logic [`ZX_DW-1:0]     bus_rdata,
	output logic                  cpu_wait,
	output logic                  mem_req,
	input  logic                  mem_ack,
	output logic [`ZX_MEM_AW-1:0] mem_addr,
	output logic                  mem_we,
	output logic [`ZX_DW-1:0]     mem_wdata,
	input  logic [`ZX_DW-1:0]     mem_rdata,
	input  logic [1:0]            model,
	input  logic [4:0]            key_data,
	input  logic                  tape_in,
	input  logic [5:0]            joystick,
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic,
	output logic                  screen_page
);

	logic                  fe_wr;
	logic                  page_wr;
	zx_io_data_u           io_data;
	logic [`ZX_MEM_AW-1:0] map_addr;
	logic                  map_ro;
	logic [`ZX_DW-1:0]     mem_data;

	zx_cpu_bus_if i_bus ();

	assign i_bus.addr  = bus_addr;
	assign i_bus.wdata = bus_wdata;
	assign i_bus.mreq  = bus_mreq;
	assign i_bus.iorq  = bus_iorq;
	assign i_bus.rd    = bus_rd;
	assign i_bus.wr    = bus_wr;
	assign i_bus.m1    = bus_m1;

	zx_bus_decode i_decode (
		.clk_sys, .reset, .bus(i_bus.sink), .mem_data, .key_data, .tape_in,
		.joystick, .fe_wr, .page_wr, .io_data, .bus_rdata
	);

	zx_ula_port i_ula (.clk_sys, .reset, .fe_wr, .io_data, .border, .ear, .mic);

	zx_paging i_paging (
		.clk_sys, .reset, .bus(i_bus.sink), .model, .page_wr, .io_data,
		.map_addr, .map_ro, .screen_page
	);

	zx_mem_access i_mem (
		.clk_sys, .reset, .bus(i_bus.sink), .map_addr, .map_ro, .mem_req, .mem_ack,
		.mem_addr, .mem_we, .mem_wdata, .mem_rdata, .mem_data, .cpu_wait
	);

endmodule

// File: verilog/zx_mem_access.sv
// ====================
// Four-phase memory request sequencer
// One access at a time, the CPU is held by cpu_wait
// ROM area writes are dropped without a request
// mem_data holds the last read byte until the next read
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

module zx_mem_access (
	input  logic                  clk_sys,
	input  logic                  reset,
	zx_cpu_bus_if.sink            bus,
	input  logic [`ZX_MEM_AW-1:0] map_addr,
	input  logic                  map_ro,
	output logic                  mem_req,
	input  logic                  mem_ack,
	output logic [`ZX_MEM_AW-1:0] mem_addr,
	output logic                  mem_we,
	output logic [`ZX_DW-1:0]     mem_wdata,
	input  logic [`ZX_DW-1:0]     mem_rdata,
	output logic [`ZX_DW-1:0]     mem_data,
	output logic                  cpu_wait
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_release,
		st_done
	} state_t;

	state_t state;
	logic   mem_cyc;
	logic   mem_cyc_d;
	logic   cyc_start;

	assign mem_cyc   = bus.mreq & (bus.rd | bus.wr);
	assign cyc_start = mem_cyc & ~mem_cyc_d & ~(bus.wr & map_ro);

	// ====================
	// Handshake FSM
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= st_idle;
			mem_cyc_d <= 1'b0;
		end else begin
			mem_cyc_d <= mem_cyc;
			case (state)
				st_idle:    if (cyc_start) state <= st_request;
				st_request: if (mem_ack) state <= st_release;
				st_release: if (!mem_ack) state <= st_done;
				// Wait here until the CPU ends its cycle
				st_done:    if (!mem_cyc) state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	// Request fields stay put for the whole handshake
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && cyc_start) begin
			mem_addr  <= map_addr;
			mem_we    <= bus.wr;
			mem_wdata <= bus.wdata;
		end
		if (state == st_request && mem_ack && !mem_we) begin
			mem_data <= mem_rdata;
		end
	end

	assign mem_req  = (state == st_request);
	assign cpu_wait = (state == st_request) || (state == st_release);

endmodule

// File: verilog/zx_paging.sv
// ====================
// 128K paging register and physical address map
// Model is sampled only while reset is high
// Lock bit holds the register until the next reset
// Code 3 on the model input behaves as the 128 model
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

module zx_paging
	import zx_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	zx_cpu_bus_if.sink           bus,
	input  logic [1:0]           model,
	input  logic                 page_wr,
	input  zx_io_data_u          io_data,
	output logic [`ZX_MEM_AW-1:0] map_addr,
	output logic                 map_ro,
	output logic                 screen_page
);

	logic [1:0]             model_q;
	zx_page_wr_t            page_reg;
	zx_page_wr_t            page_new;
	logic                   is_48;
	logic                   is_p512;
	logic [`ZX_PAGE_W-1:0]  phys_page;

	assign is_48   = (model_q == `ZX_MODEL_48);
	assign is_p512 = (model_q == `ZX_MODEL_P512);

	// Extension bits only exist on the Pentagon 512K
	always_comb begin
		page_new = io_data.page;
		if (!is_p512) begin
			page_new.ext = 2'b00;
		end
	end

	// ====================
	// Model latch and page register
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= (model == 2'd3) ? `ZX_MODEL_128 : model;
			page_reg <= '0;
		end else if (page_wr && !page_reg.lock && !is_48) begin
			page_reg <= page_new;
		end
	end

	// ====================
	// Physical page select
	// ====================
	always_comb begin
		case (bus.addr[`ZX_AW-1:`ZX_PAGE_AW])
			2'd0: begin
				// 48K model always sees the 48 BASIC ROM
				phys_page = `ZX_PAGE_W'(`ZX_ROM_PAGE) +
					`ZX_PAGE_W'(is_48 | page_reg.rom);
			end
			2'd1: phys_page = `ZX_PAGE_W'(`ZX_SCREEN_BANK);
			2'd2: phys_page = `ZX_PAGE_W'(`ZX_MID_BANK);
			default: phys_page = `ZX_PAGE_W'({page_reg.ext, page_reg.bank});
		endcase
	end

	assign map_addr    = {phys_page, bus.addr[`ZX_PAGE_AW-1:0]};
	assign map_ro      = (bus.addr[`ZX_AW-1:`ZX_PAGE_AW] == 2'd0);
	assign screen_page = page_reg.scr;

endmodule

// File: verilog/zx_ula_port.sv
// ====================
// Port FE output latch
// Loads border, ear and mic on the fe_wr strobe
// ====================
`timescale 1ns/1ps

module zx_ula_port
	import zx_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        fe_wr,
	input  zx_io_data_u io_data,
	output logic [2:0]  border,
	output logic        ear,
	output logic        mic
);

	zx_ula_wr_t ula_wr;

	// Write byte seen in its ULA layout
	assign ula_wr = io_data.ula;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (fe_wr) begin
			border <= ula_wr.border;
			ear    <= ula_wr.ear;
			mic    <= ula_wr.mic;
		end
	end

endmodule

// File: verilog/zx_bus_decode.sv
// ====================
// Bus cycle decode and CPU read data mux
// Port strobes are one cycle wide, one cycle after the I/O write edge
// Port decode is partial, as on the real machine
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

module zx_bus_decode
	import zx_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	zx_cpu_bus_if.sink        bus,
	input  logic [`ZX_DW-1:0] mem_data,
	input  logic [4:0]        key_data,
	input  logic              tape_in,
	input  logic [5:0]        joystick,
	output logic              fe_wr,
	output logic              page_wr,
	output zx_io_data_u       io_data,
	output logic [`ZX_DW-1:0] bus_rdata
);

	logic io_wr;
	logic io_rd;
	logic mem_rd;
	logic io_wr_d;
	logic io_wr_rise;

	// M1 together with IORQ is an interrupt acknowledge, not a port cycle
	assign io_wr      = bus.iorq & bus.wr & ~bus.m1;
	assign io_rd      = bus.iorq & bus.rd & ~bus.m1;
	assign mem_rd     = bus.mreq & bus.rd;
	assign io_wr_rise = io_wr & ~io_wr_d;

	// ====================
	// Port write strobes
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
			fe_wr   <= 1'b0;
			page_wr <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			// ULA answers any even port
			fe_wr   <= io_wr_rise & ~bus.addr[0];
			// 7FFD decode uses A15 and A1 only
			page_wr <= io_wr_rise & ~bus.addr[`ZX_AW-1] & ~bus.addr[1];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_wr_rise) begin
			io_data <= zx_io_data_u'(bus.wdata);
		end
	end

	// ====================
	// Read data mux
	// ====================
	always_comb begin
		if (mem_rd) begin
			bus_rdata = mem_data;
		end else if (io_rd && (bus.addr[7:0] == `ZX_PORT_KEMPSTON)) begin
			bus_rdata = {2'b00, joystick};
		end else if (io_rd && !bus.addr[0]) begin
			// Keyboard half-row with tape input on bit 6
			bus_rdata = {1'b1, ~tape_in, 1'b1, key_data};
		end else begin
			bus_rdata = `ZX_IDLE_BYTE;
		end
	end

endmodule

// File: verilog/zx_cpu_bus_if.sv
// ====================
// CPU bus fanned out inside the core
// All strobes are active high
// ====================
`timescale 1ns/1ps
`include "zx_macros.svh"

interface zx_cpu_bus_if;
	logic [`ZX_AW-1:0] addr;
	logic [`ZX_DW-1:0] wdata;
	logic              mreq;
	logic              iorq;
	logic              rd;
	logic              wr;
	logic              m1;

	// Decoding modules only look at the bus
	modport sink (
		input addr, wdata, mreq, iorq, rd, wr, m1
	);

endinterface

// File: verilog/zx_pkg.sv
// ====================
// Types for the I/O write byte
// The same byte is decoded as a port FE write or a 7FFD write
// ====================
package zx_pkg;

	// Port FE layout, bits 7:5 are not used
	typedef struct packed {
		logic [2:0] unused;
		logic       ear;
		logic       mic;
		logic [2:0] border;
	} zx_ula_wr_t;

	// Port 7FFD layout
	// ext holds the Pentagon 512K extension bits
	typedef struct packed {
		logic [1:0] ext;
		logic       lock;
		logic       rom;
		logic       scr;
		logic [2:0] bank;
	} zx_page_wr_t;

	// One write byte, two views
	typedef union packed {
		zx_ula_wr_t  ula;
		zx_page_wr_t page;
	} zx_io_data_u;

endpackage

// File: verilog/zx_macros.svh
// ====================
// Shared widths, page numbers, port decodes and model codes
// Physical memory is 1 MB made of 64 pages of 16K
// ROM page r sits at physical page ZX_ROM_PAGE + r
// ====================
`ifndef ZX_MACROS_SVH
`define ZX_MACROS_SVH

// Bus and memory widths
`define ZX_AW 16
`define ZX_DW 8
`define ZX_PAGE_AW 14
`define ZX_MEM_AW 20
`define ZX_PAGE_W 6

// Fixed page numbers
`define ZX_ROM_PAGE 32
`define ZX_SCREEN_BANK 5
`define ZX_MID_BANK 2

// Model input codes
`define ZX_MODEL_128 2'd0
`define ZX_MODEL_P512 2'd1
`define ZX_MODEL_48 2'd2

// Ports and idle bus value
`define ZX_PORT_KEMPSTON 8'h1F
`define ZX_IDLE_BYTE 8'hFF

`endif
